//--- Bender.yml
package:
  name: calc

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/calc_pkg.sv
      - verilog/calc_addsub.sv
      - verilog/calc_multiply.sv
      - verilog/calc_execute.sv
      - verilog/calc_entry.sv
      - verilog/calc_result.sv
      - verilog/calc_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/calc_tb.sv

//--- calc_top.f
+incdir+verilog
verilog/calc_pkg.sv
verilog/calc_addsub.sv
verilog/calc_multiply.sv
verilog/calc_execute.sv
verilog/calc_entry.sv
verilog/calc_result.sv
verilog/calc_top.sv
tb/calc_tb.sv

//--- tb/calc_tb.sv
// assumes at most 40 keys in a random sequence and checks every result against a behavioural model
`include "calc_macros.svh"

module calc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SEQ  = 200;
    localparam int SLOTS    = 40;
    localparam int SLOT_CYC = 25;
    localparam int MAG_MOD  = 1 << `CALC_MAG_W;

    logic              clk;
    logic              nRST;
    logic [3:0]        key;
    logic              key_valid;
    calc_pkg::op_t     op_code;
    logic              op_valid;
    logic              equal;
    logic              ready;
    calc_pkg::sm_num_t display;
    logic              overflow;
    logic              complete;

    integer        seed;
    int            checks;
    int            errors;
    // operands as they should stand inside the DUT
    logic [1:0]    m_sign;
    int            m_mag [2];
    calc_pkg::op_t m_op;

    calc_top i_calc_top (
        .clk       (clk),
        .nRST      (nRST),
        .key       (key),
        .key_valid (key_valid),
        .op_code   (op_code),
        .op_valid  (op_valid),
        .equal     (equal),
        .ready     (ready),
        .display   (display),
        .overflow  (overflow),
        .complete  (complete)
    );

    always #10 clk = ~clk;

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // four-state compare so an unknown output never slips through
    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        checks++;
        assert (exp_v === act_v) else begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp_v, act_v);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Failure: %s", what);
        end
    endtask

    task automatic clear_model();
        m_sign   = '0;
        m_mag[0] = 0;
        m_mag[1] = 0;
        m_op     = calc_pkg::OP_NONE;
    endtask

    // kind 0 is a key, 1 an op code, 2 equal
    task automatic pulse(input int kind, input int value);
        if (kind == 1) begin
            op_code = calc_pkg::op_t'(value);
        end else begin
            key = 4'(value);
        end
        key_valid = (kind == 0);
        op_valid  = (kind == 1);
        equal     = (kind == 2);
        @(negedge clk);
        key_valid = 1'b0;
        op_valid  = 1'b0;
        equal     = 1'b0;
    endtask

    // counts falling edges from the pulse until ready or complete shows up to a cap of 100
    task automatic count_until(input bit on_complete, output int n);
        n = 1;
        while (!(on_complete ? complete : ready) && n < 100) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic press(input string name, input int idx, input int kind, input int value);
        int n;
        pulse(kind, value);
        count_until(1'b0, n);
        if (kind == 0 && value <= 9) begin
            m_mag[idx] = (m_mag[idx] * 10 + value) % MAG_MOD;
            check_val({name, " key latency"}, 19, n);
        end else begin
            check_val({name, " ready after pulse"}, 1, n);
        end
        if (kind == 1 && value == calc_pkg::OP_NEG) begin
            m_sign[idx] = ~m_sign[idx];
        end else if (kind == 1) begin
            m_op = calc_pkg::op_t'(value);
        end
    endtask

    task automatic press_random(input string name, input int idx);
        int r;
        r = rand_below(16);
        if (r < 12) begin
            press(name, idx, 0, rand_below(10));
        end else if (r < 14) begin
            press(name, idx, 1, calc_pkg::OP_NEG);
        end else begin
            press(name, idx, 0, 10 + rand_below(6));
        end
    endtask

    task automatic model_result(output logic e_sign, output int e_mag, output logic e_ovf);
        logic b_sign;
        int   full;
        b_sign = m_sign[1] ^ (m_op == calc_pkg::OP_SUB);
        if (m_op == calc_pkg::OP_MUL) begin
            full   = m_mag[0] * m_mag[1];
            e_sign = m_sign[0] ^ m_sign[1];
        end else if (m_sign[0] == b_sign) begin
            full   = m_mag[0] + m_mag[1];
            e_sign = m_sign[0];
        end else if (m_mag[0] >= m_mag[1]) begin
            full   = m_mag[0] - m_mag[1];
            e_sign = m_sign[0];
        end else begin
            full   = m_mag[1] - m_mag[0];
            e_sign = b_sign;
        end
        e_ovf = (full >= MAG_MOD);
        e_mag = full % MAG_MOD;
        // zero always shows positive
        if (e_mag == 0) begin
            e_sign = 1'b0;
        end
    endtask

    task automatic finish_sequence(input string name);
        logic  e_sign;
        int    e_mag;
        logic  e_ovf;
        int    n;
        string tag;
        tag = (m_op == calc_pkg::OP_MUL) ? {name, " mul"} : {name, " add/sub"};
        model_result(e_sign, e_mag, e_ovf);
        pulse(2, 0);
        count_until(1'b1, n);
        check_val({tag, " latency"}, (m_op == calc_pkg::OP_MUL) ? 18 : 3, n);
        check_val({tag, " sign"}, e_sign, display.sign);
        check_val({tag, " magnitude"}, e_mag, display.mag);
        check_val({tag, " overflow"}, e_ovf, overflow);
        check_true(ready, "ready was low in the cycle of complete");
        @(negedge clk);
        check_true(!complete, "complete stayed high for more than one cycle");
        clear_model();
    endtask

    task automatic run_sequence(input string name);
        int n;
        int slots_b;
        repeat (rand_below(13)) press_random(name, 0);
        if (rand_below(4) == 0) begin
            press(name, 0, 2, 0);
            n = 0;
            repeat (40) begin
                @(negedge clk);
                n += complete;
            end
            check_val({name, " complete after ignored equal"}, 0, n);
        end
        press(name, 0, 1, 2 + rand_below(3));
        slots_b = rand_below(13);
        repeat (slots_b / 2) press_random(name, 1);
        // operator replaced halfway through b
        if (rand_below(4) == 0) begin
            press(name, 1, 1, 2 + rand_below(3));
        end
        repeat (slots_b - slots_b / 2) press_random(name, 1);
        finish_sequence(name);
    endtask

    // 0 is x - x, 1 is -x - -x, 2 is x + -x
    task automatic zero_test(input string name);
        int digits[$];
        int flip;
        repeat (1 + rand_below(4)) digits.push_back(rand_below(10));
        flip = rand_below(3);
        if (flip == 1) begin
            press(name, 0, 1, calc_pkg::OP_NEG);
        end
        foreach (digits[i]) press(name, 0, 0, digits[i]);
        press(name, 0, 1, (flip == 2) ? calc_pkg::OP_ADD : calc_pkg::OP_SUB);
        if (flip != 0) begin
            press(name, 1, 1, calc_pkg::OP_NEG);
        end
        foreach (digits[i]) press(name, 1, 0, digits[i]);
        finish_sequence(name);
    endtask

    initial begin
        clk       = 1'b0;
        nRST      = 1'b0;
        key       = '0;
        key_valid = 1'b0;
        op_code   = calc_pkg::OP_NONE;
        op_valid  = 1'b0;
        equal     = 1'b0;
        seed      = 32'h563d88aa;
        checks    = 0;
        errors    = 0;
        clear_model();
        repeat (10) @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);
        check_val("reset ready", 1, ready);
        check_val("reset complete", 0, complete);
        check_val("reset overflow", 0, overflow);
        check_val("reset display", 0, display);
        // ten digits wrap well past 2^15 while b stays zero
        repeat (10) press("wrap", 0, 0, rand_below(10));
        press("wrap", 0, 1, calc_pkg::OP_ADD);
        finish_sequence("wrap");
        repeat (10) zero_test("zero");
        for (int i = 0; i < NUM_SEQ; i++) begin
            run_sequence($sformatf("seq %0d", i));
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // every key slot at worst case latency plus room for the directed tests
    initial begin
        #((NUM_SEQ * SLOTS * SLOT_CYC + 20000) * 20);
        $display("Timeout: the run did not finish in the expected time");
        $display("Something failed");
        $finish;
    end

endmodule

//--- verilog/calc_addsub.sv
// sign-magnitude add or subtract, result one cycle after start, and a zero may keep a minus sign
`include "calc_macros.svh"

module calc_addsub (
    input  logic              clk,
    input  logic              nRST,
    input  logic              start,
    input  logic              sub,
    input  calc_pkg::sm_num_t a,
    input  calc_pkg::sm_num_t b,
    output logic              finish,
    output calc_pkg::sm_num_t sum,
    output logic              ovf
);

    logic                   b_sign;
    logic                   a_ge_b;
    logic [`CALC_WORD_W-1:0] mag_sum;
    calc_pkg::sm_num_t      res_d;

    // subtract is an add with b flipped
    assign b_sign  = b.sign ^ sub;
    assign a_ge_b  = (a.mag >= b.mag);
    assign mag_sum = {1'b0, a.mag} + {1'b0, b.mag};

    always_comb begin
        if (a.sign == b_sign) begin
            res_d.sign = a.sign;
            res_d.mag  = mag_sum[`CALC_MAG_W-1:0];
        end else if (a_ge_b) begin
            res_d.sign = a.sign;
            res_d.mag  = a.mag - b.mag;
        end else begin
            res_d.sign = b_sign;
            res_d.mag  = b.mag - a.mag;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sum <= res_d;
            // carry out only possible when the signs agree
            ovf <= (a.sign == b_sign) && mag_sum[`CALC_MAG_W];
        end
    end

endmodule

//--- verilog/calc_entry.sv
// keys must be clean one-cycle pulses, and any input seen while ready is low is dropped
`include "calc_macros.svh"

module calc_entry (
    input  logic                clk,
    input  logic                nRST,
    input  logic [3:0]          key,
    input  logic                key_valid,
    input  calc_pkg::op_t       op_code,
    input  logic                op_valid,
    input  logic                equal,
    output logic                ready,
    output logic                req_start,
    output calc_pkg::exec_req_t req,
    input  logic                rsp_finish,
    input  calc_pkg::exec_rsp_t rsp
);

    calc_pkg::entry_state_t state;
    calc_pkg::sm_num_t      opnd_a;
    calc_pkg::sm_num_t      opnd_b;
    calc_pkg::op_t          pending_op;
    logic [3:0]             digit_q;
    logic [`CALC_MAG_W-1:0] digit_ext;
    logic                   digit_ok;
    logic                   arith_op;
    logic                   neg_op;

    // only decimal keys count
    assign digit_ok  = key_valid && (key <= 4'd9);
    assign arith_op  = op_valid && (op_code == calc_pkg::OP_ADD ||
                                    op_code == calc_pkg::OP_SUB ||
                                    op_code == calc_pkg::OP_MUL);
    assign neg_op    = op_valid && (op_code == calc_pkg::OP_NEG);
    assign digit_ext = {{(`CALC_MAG_W-4){1'b0}}, digit_q};
    assign ready     = (state == calc_pkg::ENTER_A) || (state == calc_pkg::ENTER_B);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= calc_pkg::ENTER_A;
            opnd_a     <= '0;
            opnd_b     <= '0;
            pending_op <= calc_pkg::OP_NONE;
            req_start  <= 1'b0;
        end else begin
            req_start <= 1'b0;
            case (state)
                calc_pkg::ENTER_A: begin
                    if (arith_op) begin
                        pending_op <= op_code;
                        state      <= calc_pkg::ENTER_B;
                    end else if (neg_op) begin
                        opnd_a.sign <= ~opnd_a.sign;
                    end else if (digit_ok) begin
                        req_start <= 1'b1;
                        state     <= calc_pkg::SHIFT_A;
                    end
                end
                calc_pkg::SHIFT_A: begin
                    if (rsp_finish) begin
                        opnd_a <= rsp.value;
                        state  <= calc_pkg::ADD_DIGIT_A;
                    end
                end
                calc_pkg::ADD_DIGIT_A: begin
                    // wraps modulo 2^15
                    opnd_a.mag <= opnd_a.mag + digit_ext;
                    state      <= calc_pkg::ENTER_A;
                end
                calc_pkg::ENTER_B: begin
                    if (equal) begin
                        req_start <= 1'b1;
                        state     <= calc_pkg::ISSUE;
                    end else if (arith_op) begin
                        pending_op <= op_code;
                    end else if (neg_op) begin
                        opnd_b.sign <= ~opnd_b.sign;
                    end else if (digit_ok) begin
                        req_start <= 1'b1;
                        state     <= calc_pkg::SHIFT_B;
                    end
                end
                calc_pkg::SHIFT_B: begin
                    if (rsp_finish) begin
                        opnd_b <= rsp.value;
                        state  <= calc_pkg::ADD_DIGIT_B;
                    end
                end
                calc_pkg::ADD_DIGIT_B: begin
                    opnd_b.mag <= opnd_b.mag + digit_ext;
                    state      <= calc_pkg::ENTER_B;
                end
                calc_pkg::ISSUE: state <= calc_pkg::WAIT_RESULT;
                calc_pkg::WAIT_RESULT: begin
                    // back to a clean slate once the result is out
                    if (rsp_finish) begin
                        opnd_a     <= '0;
                        opnd_b     <= '0;
                        pending_op <= calc_pkg::OP_NONE;
                        state      <= calc_pkg::ENTER_A;
                    end
                end
                default: state <= calc_pkg::ENTER_A;
            endcase
        end
    end

    // request payload, valid whenever req_start is high
    always_ff @(posedge clk) begin
        if (state == calc_pkg::ENTER_B && equal) begin
            req.op      <= pending_op;
            req.a       <= opnd_a;
            req.b       <= opnd_b;
            req.purpose <= 1'b1;
        end else if (ready && digit_ok) begin
            digit_q     <= key;
            req.op      <= calc_pkg::OP_MUL;
            req.a       <= (state == calc_pkg::ENTER_A) ? opnd_a : opnd_b;
            req.b.sign  <= 1'b0;
            req.b.mag   <= `CALC_MAG_W'(`CALC_TEN);
            req.purpose <= 1'b0;
        end
    end

endmodule

//--- verilog/calc_execute.sv
// one request in flight at a time, and a new start while a unit is busy restarts it
module calc_execute (
    input  logic                clk,
    input  logic                nRST,
    input  logic                req_start,
    input  calc_pkg::exec_req_t req,
    output logic                rsp_finish,
    output calc_pkg::exec_rsp_t rsp
);

    logic              add_start;
    logic              add_sub;
    logic              add_finish;
    calc_pkg::sm_num_t add_sum;
    logic              add_ovf;
    logic              mul_start;
    logic              mul_finish;
    calc_pkg::sm_num_t mul_product;
    logic              mul_ovf;
    logic              purpose_q;

    assign add_start = req_start && (req.op == calc_pkg::OP_ADD || req.op == calc_pkg::OP_SUB);
    assign add_sub   = (req.op == calc_pkg::OP_SUB);
    assign mul_start = req_start && (req.op == calc_pkg::OP_MUL);

    calc_addsub i_calc_addsub (
        .clk    (clk),
        .nRST   (nRST),
        .start  (add_start),
        .sub    (add_sub),
        .a      (req.a),
        .b      (req.b),
        .finish (add_finish),
        .sum    (add_sum),
        .ovf    (add_ovf)
    );

    calc_multiply i_calc_multiply (
        .clk     (clk),
        .nRST    (nRST),
        .start   (mul_start),
        .a       (req.a),
        .b       (req.b),
        .finish  (mul_finish),
        .product (mul_product),
        .ovf     (mul_ovf)
    );

    // remember what the outstanding request was for
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            purpose_q <= 1'b0;
        end else if (req_start) begin
            purpose_q <= req.purpose;
        end
    end

    assign rsp_finish  = add_finish | mul_finish;
    assign rsp.value   = mul_finish ? mul_product : add_sum;
    assign rsp.ovf     = mul_finish ? mul_ovf : add_ovf;
    assign rsp.purpose = purpose_q;

endmodule

//--- verilog/calc_macros.svh
// sizes assume a 16-bit sign-magnitude word, and the magnitude width must stay above 4 bits
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// full word, sign bit included
`define CALC_WORD_W 16

// magnitude field below the sign bit
`define CALC_MAG_W 15

// digit entry multiplies the operand by this before adding the new digit
`define CALC_TEN 10

`endif

//--- verilog/calc_multiply.sv
// shift-add multiply, finish 16 cycles after start, and a start while busy restarts it
`include "calc_macros.svh"

module calc_multiply (
    input  logic              clk,
    input  logic              nRST,
    input  logic              start,
    input  calc_pkg::sm_num_t a,
    input  calc_pkg::sm_num_t b,
    output logic              finish,
    output calc_pkg::sm_num_t product,
    output logic              ovf
);

    localparam int CNT_W = $clog2(`CALC_MAG_W);

    logic [2*`CALC_MAG_W-1:0] acc;
    logic [2*`CALC_MAG_W-1:0] mcand;
    logic [`CALC_MAG_W-1:0]   mplier;
    logic                     sign_q;
    logic                     busy;
    logic [CNT_W-1:0]         cnt;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            cnt    <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                // last of the 15 iterations
                if (cnt == CNT_W'(`CALC_MAG_W - 1)) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= {{`CALC_MAG_W{1'b0}}, a.mag};
            mplier <= b.mag;
            sign_q <= a.sign ^ b.sign;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product.sign = sign_q;
    assign product.mag  = acc[`CALC_MAG_W-1:0];
    assign ovf          = |acc[2*`CALC_MAG_W-1:`CALC_MAG_W];

endmodule

//--- verilog/calc_pkg.sv
// shared types, sign-magnitude numbers only, and the op codes follow the keypad encoding
`include "calc_macros.svh"

package calc_pkg;

    // keypad operator codes
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    // sign on top, magnitude below
    typedef struct packed {
        logic                   sign;
        logic [`CALC_MAG_W-1:0] mag;
    } sm_num_t;

    // purpose is 1 for a final result and 0 for a digit shift
    typedef struct packed {
        op_t     op;
        sm_num_t a;
        sm_num_t b;
        logic    purpose;
    } exec_req_t;

    typedef struct packed {
        sm_num_t value;
        logic    ovf;
        logic    purpose;
    } exec_rsp_t;

    typedef enum logic [2:0] {
        ENTER_A, SHIFT_A, ADD_DIGIT_A,
        ENTER_B, SHIFT_B, ADD_DIGIT_B,
        ISSUE, WAIT_RESULT
    } entry_state_t;

endpackage

//--- verilog/calc_result.sv
// display only follows final results, and digit-shift responses pass by untouched
`include "calc_macros.svh"

module calc_result (
    input  logic                clk,
    input  logic                nRST,
    input  logic                rsp_finish,
    input  calc_pkg::exec_rsp_t rsp,
    output calc_pkg::sm_num_t   display,
    output logic                overflow,
    output logic                complete
);

    logic final_rsp;
    logic mag_zero;

    assign final_rsp = rsp_finish && rsp.purpose;
    assign mag_zero  = (rsp.value.mag == {`CALC_MAG_W{1'b0}});

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            display  <= '0;
            overflow <= 1'b0;
            complete <= 1'b0;
        end else begin
            complete <= 1'b0;
            if (final_rsp) begin
                // no negative zero on the display
                display.sign <= rsp.value.sign && !mag_zero;
                display.mag  <= rsp.value.mag;
                overflow     <= rsp.ovf;
                complete     <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/calc_top.sv
// calculator top, inputs are one-cycle pulses honoured only while ready is high
module calc_top (
    input  logic              clk,
    input  logic              nRST,
    input  logic [3:0]        key,
    input  logic              key_valid,
    input  calc_pkg::op_t     op_code,
    input  logic              op_valid,
    input  logic              equal,
    output logic              ready,
    output calc_pkg::sm_num_t display,
    output logic              overflow,
    output logic              complete
);

    logic                req_start;
    calc_pkg::exec_req_t req;
    logic                rsp_finish;
    calc_pkg::exec_rsp_t rsp;

    calc_entry i_calc_entry (
        .clk        (clk),
        .nRST       (nRST),
        .key        (key),
        .key_valid  (key_valid),
        .op_code    (op_code),
        .op_valid   (op_valid),
        .equal      (equal),
        .ready      (ready),
        .req_start  (req_start),
        .req        (req),
        .rsp_finish (rsp_finish),
        .rsp        (rsp)
    );

    calc_execute i_calc_execute (
        .clk        (clk),
        .nRST       (nRST),
        .req_start  (req_start),
        .req        (req),
        .rsp_finish (rsp_finish),
        .rsp        (rsp)
    );

    calc_result i_calc_result (
        .clk        (clk),
        .nRST       (nRST),
        .rsp_finish (rsp_finish),
        .rsp        (rsp),
        .display    (display),
        .overflow   (overflow),
        .complete   (complete)
    );

endmodule
